// ==== hdl/mmacc_param_pkg.sv ====
package mmacc_param_pkg;

  // --------------------------------------------------------------------
  // Polynomial ring
  // --------------------------------------------------------------------
  localparam int POLY_N = 16;
  localparam int COEF_W = 16;
  localparam int MOD_Q  = 65521;
  localparam int IDX_W  = $clog2(POLY_N);
  // Exponent spans 2N for the negacyclic wrap
  localparam int ROT_W  = IDX_W + 1;

  localparam logic [COEF_W:0] MOD_Q_WIDE = (COEF_W + 1)'(MOD_Q);

  // --------------------------------------------------------------------
  // GLWE RAM and flow control
  // --------------------------------------------------------------------
  localparam int SLOT_NB    = 4;
  localparam int SLOT_W     = $clog2(SLOT_NB);
  localparam int GRAM_DEPTH = SLOT_NB * POLY_N;
  localparam int GRAM_ADD_W = $clog2(GRAM_DEPTH);

  localparam int CMD_FIFO_DEPTH = 4;
  localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W      = $clog2(CMD_FIFO_DEPTH + 1);
  localparam int FEED_CREDIT_NB = 4;
  localparam int FEED_CREDIT_W  = $clog2(FEED_CREDIT_NB + 1);

  // --------------------------------------------------------------------
  // Modular arithmetic on operands below MOD_Q
  // --------------------------------------------------------------------
  function automatic logic [COEF_W-1:0] mod_add(input logic [COEF_W-1:0] a,
                                               input logic [COEF_W-1:0] b);
    logic [COEF_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum >= MOD_Q_WIDE) begin
      sum = sum - MOD_Q_WIDE;
    end
    return sum[COEF_W-1:0];
  endfunction

  function automatic logic [COEF_W-1:0] mod_sub(input logic [COEF_W-1:0] a,
                                               input logic [COEF_W-1:0] b);
    logic [COEF_W:0] diff;
    if (a >= b) begin
      diff = {1'b0, a} - {1'b0, b};
    end else begin
      diff = {1'b0, a} + MOD_Q_WIDE - {1'b0, b};
    end
    return diff[COEF_W-1:0];
  endfunction

  // Zero stays zero
  function automatic logic [COEF_W-1:0] mod_neg(input logic [COEF_W-1:0] a);
    return mod_sub('0, a);
  endfunction

endpackage

// ==== hdl/mmacc_type_pkg.sv ====
package mmacc_type_pkg;
  import mmacc_param_pkg::*;

  // --------------------------------------------------------------------
  // Plain vectors
  // --------------------------------------------------------------------
  typedef logic [COEF_W-1:0]     coef_t;
  typedef logic [IDX_W-1:0]      idx_t;
  typedef logic [SLOT_W-1:0]     slot_t;
  typedef logic [ROT_W-1:0]      rot_t;
  // Slot in the upper bits, index in the lower bits
  typedef logic [GRAM_ADD_W-1:0] gram_add_t;

  // --------------------------------------------------------------------
  // Commands and beats
  // --------------------------------------------------------------------
  typedef struct packed {
    slot_t slot;
    rot_t  rot;
  } feed_cmd_t;

  // Factor is rot_data minus data mod q
  typedef struct packed {
    idx_t  idx;
    coef_t data;
    coef_t rot_data;
    coef_t factor;
    logic  last;
  } feed_beat_t;

  // First beat of a batch overwrites the coefficient
  typedef struct packed {
    slot_t slot;
    idx_t  idx;
    coef_t data;
    logic  first;
  } acc_beat_t;

  // --------------------------------------------------------------------
  // Feed FSM
  // --------------------------------------------------------------------
  typedef enum logic {
    IDLE,
    RUN
  } feed_state_e;

endpackage

// ==== hdl/mmacc_cmd_fifo.sv ====
`timescale 1ns/1ps

module mmacc_cmd_fifo
  import mmacc_param_pkg::*;
  import mmacc_type_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,

  // Sender side, credit based
  input  logic      cmd_vld_i,
  input  feed_cmd_t cmd_i,
  output logic      cmd_credit_o,

  // Feed stage side
  output feed_cmd_t fifo_cmd_o,
  output logic      fifo_vld_o,
  input  logic      fifo_pop_i
);

  feed_cmd_t            mem [CMD_FIFO_DEPTH];
  logic [CMD_PTR_W-1:0] wr_ptr;
  logic [CMD_PTR_W-1:0] rd_ptr;
  logic [CMD_CNT_W-1:0] count;
  logic                 full;
  logic                 push;
  logic                 pop;

  // --------------------------------------------------------------------
  // Status
  // --------------------------------------------------------------------
  assign full = (count == CMD_CNT_W'(CMD_FIFO_DEPTH));
  assign pop  = fifo_pop_i & fifo_vld_o;
  // Space is guaranteed by the credits, full only guards the storage
  assign push = cmd_vld_i & (~full | pop);

  assign fifo_vld_o = (count != '0);
  assign fifo_cmd_o = mem[rd_ptr];

  // --------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cmd_i;
    end
  end

  // --------------------------------------------------------------------
  // Pointers, count and credit return
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      cmd_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit per freed entry
      cmd_credit_o <= pop;
    end
  end

endmodule

// ==== hdl/mmacc_glwe_ram.sv ====
`timescale 1ns/1ps

module mmacc_glwe_ram
  import mmacc_type_pkg::*;
(
  input  logic      clk,

  // Feed read port
  input  gram_add_t feed_rd_add_i,
  output coef_t     feed_rd_data_o,

  // Accumulate read port
  input  gram_add_t acc_rd_add_i,
  output coef_t     acc_rd_data_o,

  // Single write port
  input  logic      wr_en_i,
  input  gram_add_t wr_add_i,
  input  coef_t     wr_data_i
);

  // One entry per address, slots laid out back to back
  coef_t mem [2 ** $bits(gram_add_t)];

  // --------------------------------------------------------------------
  // Write
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_add_i] <= wr_data_i;
    end
  end

  // --------------------------------------------------------------------
  // Registered reads
  // --------------------------------------------------------------------
  // A read in the cycle of a write to the same address returns old data
  always_ff @(posedge clk) begin
    feed_rd_data_o <= mem[feed_rd_add_i];
  end

  always_ff @(posedge clk) begin
    acc_rd_data_o <= mem[acc_rd_add_i];
  end

endmodule

// ==== hdl/mmacc_feed.sv ====
`timescale 1ns/1ps

module mmacc_feed
  import mmacc_param_pkg::*;
  import mmacc_type_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,

  // Command FIFO
  input  feed_cmd_t  fifo_cmd_i,
  input  logic       fifo_vld_i,
  output logic       fifo_pop_o,

  // GRAM read port
  output gram_add_t  rd_add_o,
  input  coef_t      rd_data_i,

  // Beats towards the external product
  output logic       feed_vld_o,
  output feed_beat_t feed_o,
  input  logic       feed_credit_i
);

  feed_state_e              state;
  feed_cmd_t                cmd_q;
  idx_t                     idx_q;
  // 0 reads data at i, 1 reads the source, 2 emits
  logic [1:0]               rd_step;
  coef_t                    dat_q;
  logic [FEED_CREDIT_W-1:0] credit_cnt;

  rot_t                     src_pos;
  logic                     src_neg;
  idx_t                     src_idx;
  coef_t                    rot_val;
  logic                     emit_step;
  logic                     send;

  // --------------------------------------------------------------------
  // Command pop
  // --------------------------------------------------------------------
  assign fifo_pop_o = (state == IDLE) & fifo_vld_i;

  always_ff @(posedge clk) begin
    if (fifo_pop_o) begin
      cmd_q <= fifo_cmd_i;
    end
  end

  // --------------------------------------------------------------------
  // Rotation addressing
  // --------------------------------------------------------------------
  // j = (i - r) mod 2N, upper half means negated coefficient
  assign src_pos = {1'b0, idx_q} - cmd_q.rot;
  assign src_neg = src_pos[ROT_W-1];
  assign src_idx = src_pos[IDX_W-1:0];

  assign rd_add_o = (rd_step == 2'd0) ? {cmd_q.slot, idx_q} : {cmd_q.slot, src_idx};

  // Data at i comes back on the step after its read
  always_ff @(posedge clk) begin
    if ((state == RUN) && (rd_step == 2'd1)) begin
      dat_q <= rd_data_i;
    end
  end

  assign rot_val   = src_neg ? mod_neg(rd_data_i) : rd_data_i;
  assign emit_step = (state == RUN) && (rd_step == 2'd2);
  // Source read is reissued while stalled, so rd_data_i stays valid
  assign send      = emit_step && (credit_cnt != '0);

  // --------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state   <= IDLE;
      idx_q   <= '0;
      rd_step <= 2'd0;
    end else begin
      case (state)
        IDLE: begin
          if (fifo_vld_i) begin
            state   <= RUN;
            idx_q   <= '0;
            rd_step <= 2'd0;
          end
        end
        RUN: begin
          if (rd_step != 2'd2) begin
            rd_step <= rd_step + 1'b1;
          end else if (send) begin
            rd_step <= 2'd0;
            idx_q   <= idx_q + 1'b1;
            if (idx_q == IDX_W'(POLY_N - 1)) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Output beat and credits
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (send) begin
      feed_o.idx      <= idx_q;
      feed_o.data     <= dat_q;
      feed_o.rot_data <= rot_val;
      feed_o.factor   <= mod_sub(rot_val, dat_q);
      feed_o.last     <= (idx_q == IDX_W'(POLY_N - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      feed_vld_o <= 1'b0;
      credit_cnt <= FEED_CREDIT_W'(FEED_CREDIT_NB);
    end else begin
      feed_vld_o <= send;
      case ({feed_credit_i, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// ==== hdl/mmacc_acc.sv ====
`timescale 1ns/1ps

module mmacc_acc
  import mmacc_param_pkg::*;
  import mmacc_type_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,

  // Result beats, no back-pressure
  input  logic      acc_vld_i,
  input  acc_beat_t acc_i,

  // GRAM read port
  output gram_add_t rd_add_o,
  input  coef_t     rd_data_i,

  // GRAM write port
  output logic      wr_en_o,
  output gram_add_t wr_add_o,
  output coef_t     wr_data_o
);

  logic      s1_vld;
  acc_beat_t s1_beat;
  gram_add_t s1_add;

  // Write issued one cycle before wr_*_o, not yet visible in the RAM read
  logic      prev_wr_en;
  gram_add_t prev_wr_add;
  coef_t     prev_wr_data;

  coef_t     stored;
  coef_t     result;

  // --------------------------------------------------------------------
  // Stage one, read issue
  // --------------------------------------------------------------------
  assign rd_add_o = {acc_i.slot, acc_i.idx};

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= acc_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_beat <= acc_i;
  end

  assign s1_add = {s1_beat.slot, s1_beat.idx};

  // --------------------------------------------------------------------
  // Stage two, forwarding and add
  // --------------------------------------------------------------------
  // Newest write has priority
  always_comb begin
    if (wr_en_o && (wr_add_o == s1_add)) begin
      stored = wr_data_o;
    end else if (prev_wr_en && (prev_wr_add == s1_add)) begin
      stored = prev_wr_data;
    end else begin
      stored = rd_data_i;
    end
  end

  assign result = s1_beat.first ? s1_beat.data : mod_add(stored, s1_beat.data);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_en_o    <= 1'b0;
      prev_wr_en <= 1'b0;
    end else begin
      wr_en_o    <= s1_vld;
      prev_wr_en <= wr_en_o;
    end
  end

  always_ff @(posedge clk) begin
    wr_add_o     <= s1_add;
    wr_data_o    <= result;
    prev_wr_add  <= wr_add_o;
    prev_wr_data <= wr_data_o;
  end

endmodule

// ==== hdl/mmacc_top.sv ====
`timescale 1ns/1ps

module mmacc_top
  import mmacc_type_pkg::*;
(
  input  logic       clk,
  input  logic       s_rst_n,

  // Commands
  input  logic       cmd_vld_i,
  input  feed_cmd_t  cmd_i,
  output logic       cmd_credit_o,

  // Feed output
  output logic       feed_vld_o,
  output feed_beat_t feed_o,
  input  logic       feed_credit_i,

  // Accumulate input
  input  logic       acc_vld_i,
  input  acc_beat_t  acc_i
);

  feed_cmd_t fifo_cmd;
  logic      fifo_vld;
  logic      fifo_pop;

  gram_add_t feed_rd_add;
  coef_t     feed_rd_data;
  gram_add_t acc_rd_add;
  coef_t     acc_rd_data;
  logic      wr_en;
  gram_add_t wr_add;
  coef_t     wr_data;

  // --------------------------------------------------------------------
  // Command queue and feed
  // --------------------------------------------------------------------
  mmacc_cmd_fifo mmacc_cmd_fifo_i (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .cmd_vld_i    (cmd_vld_i),
    .cmd_i        (cmd_i),
    .cmd_credit_o (cmd_credit_o),
    .fifo_cmd_o   (fifo_cmd),
    .fifo_vld_o   (fifo_vld),
    .fifo_pop_i   (fifo_pop)
  );

  mmacc_feed mmacc_feed_i (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .fifo_cmd_i    (fifo_cmd),
    .fifo_vld_i    (fifo_vld),
    .fifo_pop_o    (fifo_pop),
    .rd_add_o      (feed_rd_add),
    .rd_data_i     (feed_rd_data),
    .feed_vld_o    (feed_vld_o),
    .feed_o        (feed_o),
    .feed_credit_i (feed_credit_i)
  );

  // --------------------------------------------------------------------
  // Accumulate and GRAM
  // --------------------------------------------------------------------
  mmacc_acc mmacc_acc_i (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .acc_vld_i (acc_vld_i),
    .acc_i     (acc_i),
    .rd_add_o  (acc_rd_add),
    .rd_data_i (acc_rd_data),
    .wr_en_o   (wr_en),
    .wr_add_o  (wr_add),
    .wr_data_o (wr_data)
  );

  mmacc_glwe_ram mmacc_glwe_ram_i (
    .clk            (clk),
    .feed_rd_add_i  (feed_rd_add),
    .feed_rd_data_o (feed_rd_data),
    .acc_rd_add_i   (acc_rd_add),
    .acc_rd_data_o  (acc_rd_data),
    .wr_en_i        (wr_en),
    .wr_add_i       (wr_add),
    .wr_data_i      (wr_data)
  );

endmodule

// ==== sim/mmacc_tb_util.svh ====
`ifndef MMACC_TB_UTIL_SVH
`define MMACC_TB_UTIL_SVH

// --------------------------------------------------------------------
// Random source and reference model
// --------------------------------------------------------------------
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = 32'h79e6;
// Slot contents as the accumulate rule leaves them
coef_t       model [SLOT_NB][POLY_N];

// Galois form, one step per bit
function automatic logic lfsr_bit();
  logic out;
  out        = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ LFSR_TAPS;
  end
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

function automatic coef_t rand_coef();
  return coef_t'(rand_bits(COEF_W) % MOD_Q);
endfunction

// Negacyclic rotation by X^rot, source index j = (i - rot) mod 2N
function automatic feed_beat_t expect_beat(input int slot, input int rot, input int i);
  feed_beat_t b;
  int         j;
  int         src;
  int         dat;
  j   = (i - rot + 2 * POLY_N) % (2 * POLY_N);
  dat = model[slot][i];
  if (j < POLY_N) begin
    src = model[slot][j];
  end else begin
    src = (MOD_Q - int'(model[slot][j - POLY_N])) % MOD_Q;
  end
  b.idx      = idx_t'(i);
  b.data     = coef_t'(dat);
  b.rot_data = coef_t'(src);
  b.factor   = coef_t'((src - dat + MOD_Q) % MOD_Q);
  b.last     = (i == POLY_N - 1);
  return b;
endfunction

// --------------------------------------------------------------------
// Compare tasks
// --------------------------------------------------------------------
function automatic string beat_str(input feed_beat_t b);
  return $sformatf("idx=%0d data=%h rot_data=%h factor=%h last=%b",
                   b.idx, b.data, b.rot_data, b.factor, b.last);
endfunction

task automatic check_beat(input string name, input feed_beat_t exp, input feed_beat_t act);
  if (act !== exp) begin
    report_failure($sformatf("[ERROR] %s: expected %s, actual %s",
                             name, beat_str(exp), beat_str(act)));
  end
endtask

task automatic check_coef(input string name, input coef_t exp, input coef_t act);
  if (act !== exp) begin
    report_failure($sformatf("[ERROR] %s: expected coef %h, actual %h", name, exp, act));
  end
endtask

// --------------------------------------------------------------------
// Drive helpers
// --------------------------------------------------------------------
// One cycle: clear pulses, sample outputs, return feed credits
task automatic tick();
  @(posedge clk);
  #DRIVE_DLY;
  cmd_vld_i     = 1'b0;
  acc_vld_i     = 1'b0;
  feed_credit_i = 1'b0;
  if (cmd_credit_o === 1'b1) begin
    cmd_credits = cmd_credits + 1;
    credit_seen = credit_seen + 1;
    if (cmd_credits > CMD_FIFO_DEPTH) begin
      report_failure("Command FIFO returned more credits than it has entries");
    end
  end
  if (feed_vld_o === 1'b1) begin
    beat_q.push_back(feed_o);
    outstanding     = outstanding + 1;
    pending_credits = pending_credits + 1;
    if (outstanding > FEED_CREDIT_NB) begin
      report_failure("Feed stage sent more beats than it had credits");
    end
  end
  // Credit back for a received beat, after a random gap when enabled
  if (pending_credits > 0) begin
    if (gap_cnt == 0) begin
      feed_credit_i   = 1'b1;
      pending_credits = pending_credits - 1;
      outstanding     = outstanding - 1;
      gap_cnt         = (gap_bits > 0) ? gap_min + int'(rand_bits(gap_bits)) : 0;
    end else begin
      gap_cnt = gap_cnt - 1;
    end
  end
endtask

task automatic drive_acc(input int slot, input int idx, input coef_t data, input logic first);
  tick();
  acc_vld_i     = 1'b1;
  acc_i.slot    = slot_t'(slot);
  acc_i.idx     = idx_t'(idx);
  acc_i.data    = data;
  acc_i.first   = first;
  if (first) begin
    model[slot][idx] = data;
  end else begin
    model[slot][idx] = coef_t'((int'(model[slot][idx]) + int'(data)) % MOD_Q);
  end
endtask

task automatic send_cmd(input int slot, input int rot);
  tick();
  while (cmd_credits == 0) begin
    tick();
  end
  cmd_vld_i   = 1'b1;
  cmd_i.slot  = slot_t'(slot);
  cmd_i.rot   = rot_t'(rot);
  cmd_credits = cmd_credits - 1;
endtask

task automatic wait_beat(output feed_beat_t b);
  while (beat_q.size() == 0) begin
    tick();
  end
  b = beat_q.pop_front();
endtask

`endif

// ==== sim/mmacc_tb.sv ====
`timescale 1ns/1ps

module mmacc_tb
  import mmacc_param_pkg::*;
  import mmacc_type_pkg::*;
();

  localparam int DRIVE_DLY      = 2;
  // Run length: feed commands, accumulate beats and credit gaps
  localparam int CMD_NB         = 15;
  localparam int CMD_CYCLES     = 3 * POLY_N + 8;
  localparam int ACC_CYCLES     = 12 * POLY_N + 16;
  localparam int GAP_CYCLES     = 12 * POLY_N;
  localparam int TIMEOUT_CYCLES = 2 * (CMD_NB * CMD_CYCLES + ACC_CYCLES + GAP_CYCLES);

  logic       clk;
  logic       s_rst_n;
  logic       cmd_vld_i;
  feed_cmd_t  cmd_i;
  logic       cmd_credit_o;
  logic       feed_vld_o;
  feed_beat_t feed_o;
  logic       feed_credit_i;
  logic       acc_vld_i;
  acc_beat_t  acc_i;

  int         cmd_credits     = CMD_FIFO_DEPTH;
  int         credit_seen     = 0;
  int         outstanding     = 0;
  int         pending_credits = 0;
  int         gap_cnt         = 0;
  int         gap_bits        = 0;
  int         gap_min         = 0;
  int         cycle_cnt       = 0;
  feed_beat_t beat_q [$];

  always #20 clk = ~clk;

  mmacc_top mmacc_top_i (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .cmd_vld_i     (cmd_vld_i),
    .cmd_i         (cmd_i),
    .cmd_credit_o  (cmd_credit_o),
    .feed_vld_o    (feed_vld_o),
    .feed_o        (feed_o),
    .feed_credit_i (feed_credit_i),
    .acc_vld_i     (acc_vld_i),
    .acc_i         (acc_i)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

`include "mmacc_tb_util.svh"

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("Timeout: the DUT did not deliver all beats in time");
    end
  end

  // --------------------------------------------------------------------
  // Test tasks
  // --------------------------------------------------------------------
  task automatic collect_beats(input string name, input int slot, input int rot);
    feed_beat_t b;
    for (int i = 0; i < POLY_N; i++) begin
      wait_beat(b);
      check_beat(name, expect_beat(slot, rot, i), b);
    end
  endtask

  // All credits back and no stray beats
  task automatic finish_test(input string name);
    while (pending_credits != 0) begin
      tick();
    end
    repeat (8) tick();
    if (beat_q.size() != 0) begin
      report_failure($sformatf("%s: feed stage sent beats no command asked for", name));
    end
  endtask

  task automatic test_load_identity();
    for (int s = 0; s < SLOT_NB; s++) begin
      for (int i = 0; i < POLY_N; i++) begin
        drive_acc(s, i, rand_coef(), 1'b1);
      end
    end
    repeat (4) tick();
    for (int s = 0; s < SLOT_NB; s++) begin
      send_cmd(s, 0);
      collect_beats("test_load_identity", s, 0);
    end
    finish_test("test_load_identity");
  endtask

  task automatic test_rotation();
    int rots [5] = '{1, 7, 16, 21, 31};
    foreach (rots[k]) begin
      send_cmd(1, rots[k]);
      collect_beats("test_rotation", 1, rots[k]);
    end
    finish_test("test_rotation");
  endtask

  task automatic test_accumulate();
    feed_beat_t b;
    for (int i = 0; i < POLY_N; i++) begin
      drive_acc(2, i, coef_t'(MOD_Q - 1 - rand_bits(4)), 1'b1);
    end
    // Pairs on one address, back to back, near q so sums wrap
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < POLY_N; i++) begin
        drive_acc(2, i, coef_t'(MOD_Q - 1 - rand_bits(4)), 1'b0);
        drive_acc(2, i, rand_coef(), 1'b0);
      end
    end
    // Same address two beats apart, past the newest write
    for (int i = 0; i < POLY_N; i += 2) begin
      drive_acc(2, i, coef_t'(MOD_Q - 1 - rand_bits(4)), 1'b0);
      drive_acc(2, i + 1, coef_t'(MOD_Q - 1 - rand_bits(4)), 1'b0);
      drive_acc(2, i, rand_coef(), 1'b0);
      drive_acc(2, i + 1, rand_coef(), 1'b0);
    end
    repeat (POLY_N) drive_acc(2, int'(rand_bits(4)), coef_t'(MOD_Q - 1 - rand_bits(4)), 1'b0);
    repeat (4) tick();
    send_cmd(2, 0);
    for (int i = 0; i < POLY_N; i++) begin
      wait_beat(b);
      check_coef("test_accumulate", model[2][i], b.data);
      check_beat("test_accumulate", expect_beat(2, 0, i), b);
    end
    finish_test("test_accumulate");
  endtask

  task automatic test_feed_credits();
    // Gaps longer than the beat period, so the credits run out
    gap_min  = 4;
    gap_bits = 3;
    send_cmd(3, 5);
    collect_beats("test_feed_credits", 3, 5);
    finish_test("test_feed_credits");
    gap_bits = 0;
    gap_min  = 0;
  endtask

  task automatic test_cmd_credits();
    int rots [4] = '{3, 0, 17, 30};
    int base;
    base = credit_seen;
    if (cmd_credits != CMD_FIFO_DEPTH) begin
      report_failure("test_cmd_credits: sender does not hold all command credits");
    end
    for (int s = 0; s < SLOT_NB; s++) begin
      send_cmd(s, rots[s]);
    end
    for (int s = 0; s < SLOT_NB; s++) begin
      collect_beats("test_cmd_credits", s, rots[s]);
    end
    while (credit_seen - base < CMD_FIFO_DEPTH) begin
      tick();
    end
    finish_test("test_cmd_credits");
    if (credit_seen - base != CMD_FIFO_DEPTH) begin
      report_failure("test_cmd_credits: wrong number of command credits came back");
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    clk           = 1'b0;
    s_rst_n       = 1'b0;
    cmd_vld_i     = 1'b0;
    cmd_i         = '0;
    feed_credit_i = 1'b0;
    acc_vld_i     = 1'b0;
    acc_i         = '0;
    repeat (4) tick();
    s_rst_n = 1'b1;
    if ((feed_vld_o !== 1'b0) || (cmd_credit_o !== 1'b0)) begin
      report_failure("Feed valid or command credit is not low after reset");
    end
    test_load_identity();
    test_rotation();
    test_accumulate();
    test_feed_credits();
    test_cmd_credits();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== mmacc_top.f ====
+incdir+sim
hdl/mmacc_param_pkg.sv
hdl/mmacc_type_pkg.sv
hdl/mmacc_cmd_fifo.sv
hdl/mmacc_glwe_ram.sv
hdl/mmacc_feed.sv
hdl/mmacc_acc.sv
hdl/mmacc_top.sv
sim/mmacc_tb.sv
